//--- verilog/hackPkg.sv
/* Shared widths, memory map and UART timing of the HACK computer.
   Data addresses are 15 bits, the program counter covers a 256-word ROM. */

`default_nettype none

package hackPkg;

	localparam int wordBits = 16;
	localparam int addrBits = 15;
	localparam int pcBits = 8; // 256-word ROM

	typedef logic [wordBits-1:0] wordT;
	typedef logic [addrBits-1:0] addrT;
	typedef logic [pcBits-1:0] pcT;

	// RAM occupies 0 .. ramWords-1
	localparam int ramWords = 3840;
	localparam int ramAddrBits = $clog2(ramWords);

	// Memory-mapped IO
	localparam addrT addrLed = 15'd4096; // Two low bits kept
	localparam addrT addrBut = 15'd4097; // Read only
	localparam addrT addrUartTx = 15'd4098; // Write sends low byte, bit 15 reads busy

	// Serial bit period in clocks
	localparam int uartClocksPerBit = 8;

endpackage

`default_nettype wire

//--- verilog/memBus.sv
/* CPU data bus. Writes commit on the edge where write is high,
   reads are combinational from address to rdata. */

`default_nettype none

interface memBus;
	import hackPkg::*;

	addrT address; // Data address from A
	wordT wdata; // ALU result
	logic write; // One cycle strobe
	wordT rdata; // Decoded read data

	modport cpu (
		output address,
		output wdata,
		output write,
		input rdata
	);

	modport mem (
		input address,
		input wdata,
		input write,
		output rdata
	);

endinterface

`default_nettype wire

//--- verilog/hackCpu.sv
/* HACK CPU, one instruction per cycle. M is read combinationally from the bus.
   Jump targets use the low pcBits of A, so programs must fit in 256 words. */

`default_nettype none

module hackCpu (
	input wire clk,
	input wire arstN,
	input wire hackPkg::wordT instruction,
	output hackPkg::pcT pc,
	memBus.cpu bus
);
	import hackPkg::*;

	logic isC; // C-instruction when bit 15 set
	logic aBit; // Select M instead of A
	logic zx, nx, zy, ny, f, no; // ALU control
	logic dA, dD, dM; // Destinations
	logic jLt, jEq, jGt; // Jump conditions
	wordT aQ;
	wordT dQ;
	wordT x;
	wordT y;
	wordT aluOut;
	logic zr; // Result zero
	logic ng; // Result negative
	logic jump;

	assign isC = instruction[15];
	assign aBit = instruction[12];
	assign zx = instruction[11];
	assign nx = instruction[10];
	assign zy = instruction[9];
	assign ny = instruction[8];
	assign f = instruction[7];
	assign no = instruction[6];
	assign dA = instruction[5];
	assign dD = instruction[4];
	assign dM = instruction[3];
	assign jLt = instruction[2];
	assign jEq = instruction[1];
	assign jGt = instruction[0];

	// ALU, covers the 18 HACK functions through the six control bits
	always_comb begin
		x = zx ? '0 : dQ;
		x = nx ? ~x : x;
		y = aBit ? bus.rdata : aQ; // A or M operand
		y = zy ? '0 : y;
		y = ny ? ~y : y;
		aluOut = f ? x + y : x & y;
		aluOut = no ? ~aluOut : aluOut;
	end

	assign zr = (aluOut == '0);
	assign ng = aluOut[wordBits-1];
	assign jump = isC & ((jLt & ng) | (jEq & zr) | (jGt & ~ng & ~zr));

	// Address always comes from the current A
	assign bus.address = addrT'(aQ);
	assign bus.wdata = aluOut;
	assign bus.write = isC & dM;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			aQ <= '0;
			dQ <= '0;
			pc <= '0;
		end else begin
			if (!isC)
				aQ <= instruction; // A-instruction loads constant
			else if (dA)
				aQ <= aluOut;
			if (isC && dD)
				dQ <= aluOut;
			pc <= jump ? pcT'(aQ) : pc + 1'b1; // Wraps at ROM end
		end
	end

	// Memory writes only from C-instructions
	aWriteOnlyFromC: assert property (
		@(posedge clk) disable iff (!arstN) !instruction[15] |-> !bus.write
	) else $error("hackCpu write strobe during A-instruction");

endmodule

`default_nettype wire

//--- verilog/hackRom.sv
/* Instruction ROM of 256 words, filled from prog.hex at elaboration.
   Words past the end of the file read as zero, a harmless @0. */

`default_nettype none

module hackRom (
	input wire hackPkg::pcT pc,
	output hackPkg::wordT instruction
);
	import hackPkg::*;

	wordT romQ [2**pcBits];

	initial begin
		for (int i = 0; i < 2**pcBits; i++)
			romQ[i] = '0; // Unfilled words
		$readmemh("prog.hex", romQ);
	end

	// Asynchronous read
	assign instruction = romQ[pc];

endmodule

`default_nettype wire

//--- verilog/hackMemory.sv
/* Data memory map: RAM below ramWords, then LED, buttons and UART transmit.
   Unmapped addresses read zero and ignore writes. No wait states. */

`default_nettype none

module hackMemory (
	input wire clk,
	input wire arstN,
	memBus.mem bus,
	input wire [1:0] but,
	output logic [1:0] led,
	output logic uartLoad,
	output logic [7:0] uartByte,
	input wire uartBusy
);
	import hackPkg::*;

	logic selRam;
	logic selLed;
	logic selBut;
	logic selUart;
	wordT ram [ramWords];
	logic [1:0] butQ; // Sampled buttons

	// Region decode
	assign selRam = (bus.address < ramWords);
	assign selLed = (bus.address == addrLed);
	assign selBut = (bus.address == addrBut);
	assign selUart = (bus.address == addrUartTx);

	// RAM write port
	always_ff @(posedge clk) begin
		if (bus.write && selRam)
			ram[bus.address[ramAddrBits-1:0]] <= bus.wdata;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			led <= '0;
			butQ <= '0;
		end else begin
			butQ <= but; // One cycle latency
			if (bus.write && selLed)
				led <= bus.wdata[1:0];
		end
	end

	// UART gets the strobe and low byte, busy comes back on read
	assign uartLoad = bus.write & selUart;
	assign uartByte = bus.wdata[7:0];

	// Read mux
	always_comb begin
		if (selRam)
			bus.rdata = ram[bus.address[ramAddrBits-1:0]];
		else if (selLed)
			bus.rdata = {{(wordBits-2){1'b0}}, led};
		else if (selBut)
			bus.rdata = {{(wordBits-2){1'b0}}, butQ};
		else if (selUart)
			bus.rdata = {uartBusy, {(wordBits-1){1'b0}}}; // Busy in bit 15
		else
			bus.rdata = '0;
	end

	aOneRegion: assert property (
		@(posedge clk) disable iff (!arstN) $onehot0({selRam, selLed, selBut, selUart})
	) else $error("hackMemory overlapping region selects");

endmodule

`default_nettype wire

//--- verilog/uartTx.sv
/* 8N1 transmitter, clocksPerBit clocks per bit, clocksPerBit >= 2.
   A load while busy is dropped, software polls busy first. */

`default_nettype none

module uartTx #(
	parameter int clocksPerBit = hackPkg::uartClocksPerBit
) (
	input wire clk,
	input wire arstN,
	input wire load,
	input wire [7:0] data,
	output logic busy,
	output logic tx
);

	logic [9:0] shiftQ; // Stop, data, start
	logic [3:0] bitCnt; // Bits sent in frame
	logic [$clog2(clocksPerBit)-1:0] baudCnt;
	logic bitEnd;

	assign bitEnd = (baudCnt == ($bits(baudCnt))'(clocksPerBit - 1));

	// Line driven straight from the register, idles high
	assign tx = shiftQ[0];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			shiftQ <= '1;
			bitCnt <= '0;
			baudCnt <= '0;
			busy <= 1'b0;
		end else if (!busy) begin
			if (load) begin
				shiftQ <= {1'b1, data, 1'b0}; // Start bit out next cycle
				bitCnt <= '0;
				baudCnt <= '0;
				busy <= 1'b1;
			end
		end else if (bitEnd) begin
			baudCnt <= '0;
			shiftQ <= {1'b1, shiftQ[9:1]}; // LSB first, ones fill
			bitCnt <= bitCnt + 1'b1;
			if (bitCnt == 4'd9)
				busy <= 1'b0; // Stop bit done
		end else begin
			baudCnt <= baudCnt + 1'b1;
		end
	end

	aIdleHigh: assert property (
		@(posedge clk) disable iff (!arstN) !busy |-> tx
	) else $error("uartTx line low while idle");

	// Accepted load shows a start bit on the next cycle
	aStartBit: assert property (
		@(posedge clk) disable iff (!arstN) (load && !busy) |=> (busy && !tx)
	) else $error("uartTx start bit missing after load");

endmodule

`default_nettype wire

//--- verilog/hackTop.sv
/* HACK computer: CPU, instruction ROM, memory map and UART transmit.
   Clock and reset come straight from the pins, reset is asynchronous. */

`default_nettype none

module hackTop (
	input wire clk,
	input wire arstN,
	input wire [1:0] but, // User buttons
	output logic [1:0] led, // LED register
	output logic uartTx // Serial out, idles high
);
	import hackPkg::*;

	wordT instruction;
	pcT pc;
	logic uartLoad;
	logic [7:0] uartByte;
	logic uartBusy;

	memBus bus ();

	hackCpu cpu (
		.clk(clk),
		.arstN(arstN),
		.instruction(instruction),
		.pc(pc),
		.bus(bus.cpu)
	);

	hackRom rom (
		.pc(pc),
		.instruction(instruction)
	);

	hackMemory mem (
		.clk(clk),
		.arstN(arstN),
		.bus(bus.mem),
		.but(but),
		.led(led),
		.uartLoad(uartLoad),
		.uartByte(uartByte),
		.uartBusy(uartBusy)
	);

	uartTx #(
		.clocksPerBit(uartClocksPerBit)
	) txUnit (
		.clk(clk),
		.arstN(arstN),
		.load(uartLoad),
		.data(uartByte),
		.busy(uartBusy),
		.tx(uartTx)
	);

endmodule

`default_nettype wire

//--- dv/clkGen.sv
/* Testbench clock of 100 ns and active low reset.
   Reset is held for resetCycles at start and again while restart is high. */

`default_nettype none

module clkGen #(
	parameter int resetCycles = 16
) (
	input wire restart, // Reset request from the testbench
	output logic clk,
	output logic arstN
);
	timeunit 1ns;
	timeprecision 1ps;

	logic porN; // Power-on reset, released once

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		porN = 1'b1;
		#1 porN = 1'b0; // Real falling edge for the async flops
		repeat (resetCycles) @(posedge clk);
		#10 porN = 1'b1;
	end

	assign arstN = porN & ~restart;

endmodule

`default_nettype wire

//--- dv/hackTb.sv
/* Testbench for hackTop with prog.hex loaded. Expects one byte 0x37 after each reset,
   then the button register echoed on the LEDs. UART bits are sampled at falling clocks. */

`default_nettype none

module hackTb;
	timeunit 1ns;
	timeprecision 1ps;
	import hackPkg::*;

	localparam int halfBit = uartClocksPerBit / 2;
	localparam int resetTimeout = 64; // Cycles
	localparam int frameTimeout = 4000; // Cycles to the start bit
	localparam int echoHold = 40; // Cycles per button value
	localparam int echoCount = 8;
	localparam int resetCycles = 16;
	localparam logic [7:0] sumByte = 8'h37; // 1 + 2 + ... + 10

	logic clk;
	logic arstN;
	logic restart;
	logic [1:0] but;
	wire [1:0] led;
	wire uartTx;
	logic expectIdle; // Line must stay high
	int seed;

	clkGen #(.resetCycles(resetCycles)) clocks (.restart(restart), .clk(clk), .arstN(arstN));

	hackTop uut (
		.clk(clk),
		.arstN(arstN),
		.but(but),
		.led(led),
		.uartTx(uartTx)
	);

	task automatic reportFailure(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "hackTb stopped at the first error");
	endtask

	// Reset values on the pins
	resetState: assert property (
		@(posedge clk) !arstN |-> (led == 2'b00 && uartTx)
	) else reportFailure($sformatf("FAIL reset expected led 0 tx 1 actual led %0d tx %b",
		led, uartTx));

	// No second start bit once the stop bit began
	lineIdle: assert property (
		@(posedge clk) disable iff (!arstN) expectIdle |-> uartTx
	) else reportFailure("UART line went low again after the stop bit began");

	task automatic waitResetRelease();
		int waited;
		waited = 0;
		while (!arstN && waited < resetTimeout) begin
			@(negedge clk);
			waited++;
		end
		released: assert (arstN) else reportFailure("reset was not released in time");
	endtask

	task automatic receiveFrame(input logic [7:0] expected);
		int waited;
		logic [7:0] rxByte;
		waited = 0;
		rxByte = '0;
		while (uartTx && waited < frameTimeout) begin
			@(negedge clk);
			waited++;
		end
		startSeen: assert (!uartTx) else reportFailure("no UART start bit within the timeout");
		repeat (halfBit) @(negedge clk); // Middle of start bit
		startBit: assert (!uartTx) else reportFailure(
			$sformatf("FAIL uartFrame start bit expected 0 actual %b", uartTx));
		for (int i = 0; i < 8; i++) begin
			repeat (uartClocksPerBit) @(negedge clk);
			rxByte[i] = uartTx; // LSB first
		end
		repeat (halfBit) @(negedge clk);
		expectIdle = 1'b1; // Stop bit starts here
		repeat (halfBit) @(negedge clk);
		stopBit: assert (uartTx) else reportFailure(
			$sformatf("FAIL uartFrame stop bit expected 1 actual %b", uartTx));
		dataByte: assert (rxByte == expected) else reportFailure(
			$sformatf("FAIL uartFrame expected %02h actual %02h", expected, rxByte));
	endtask

	task automatic echoButton(input logic [1:0] value);
		int waited;
		@(posedge clk);
		#10 but = value;
		waited = 0;
		while (led != value && waited < echoHold) begin
			@(negedge clk);
			waited++;
		end
		ledMatch: assert (led == value) else reportFailure(
			$sformatf("FAIL butEcho expected %0d actual %0d", value, led));
		repeat (echoHold - waited) @(negedge clk); // Rest of the hold
	endtask

	initial begin
		seed = 40;
		but = 2'b00;
		restart = 1'b0;
		expectIdle = 1'b0;
		@(posedge clk); // Power-on reset active from here
		waitResetRelease();
		receiveFrame(sumByte);
		for (int n = 0; n < echoCount; n++)
			echoButton(2'($random(seed)));
		echoButton(2'b11); // LEDs lit before the restart
		@(posedge clk);
		#10;
		expectIdle = 1'b0;
		restart = 1'b1; // Mid-loop reset
		repeat (resetCycles) @(posedge clk);
		ledCleared: assert (led == 2'b00) else reportFailure(
			$sformatf("FAIL restart expected 0 actual %0d", led));
		#10 restart = 1'b0;
		waitResetRelease();
		receiveFrame(sumByte);
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/prog.hex
// HACK machine code, one hex instruction per line, starting at ROM address 0
0010 // @16, sum
EA88 // M=0
0011 // @17, counter
EFC8 // M=1
0011 // 4 loop: @17
FC10 // D=M
000A // @10
E4D0 // D=D-A
0012 // @18
E301 // D;JGT, counter past 10
0011 // @17
FC10 // D=M
0010 // @16
F088 // M=D+M
0011 // @17
FDC8 // M=M+1
0004 // @4
EA87 // 0;JMP
1002 // 18 poll: @4098
FC10 // D=M
0012 // @18
E304 // D;JLT, busy in bit 15
0010 // @16
FC10 // D=M
1002 // @4098
E308 // M=D, send sum
1002 // 26 poll: @4098
FC10 // D=M
001A // @26
E304 // D;JLT
1001 // 30 echo: @4097
FC10 // D=M
1000 // @4096
E308 // M=D
001E // @30
EA87 // 0;JMP

//--- flist.f
verilog/hackPkg.sv
verilog/memBus.sv
verilog/hackCpu.sv
verilog/hackRom.sv
verilog/hackMemory.sv
verilog/uartTx.sv
verilog/hackTop.sv
dv/clkGen.sv
dv/hackTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run from verilog/ so that the ROM finds prog.hex
set -e

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module hackTb -f flist.f

cd verilog
out=$(../obj_dir/VhackTb 2>&1) || true
cd ..
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
	exit 0
else
	exit 1
fi
